//--- dcache_pkg.sv
package dcache_pkg;

    // address and data widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [63:0] block_t;
    typedef logic [2:0]  offset_t;
    typedef logic [28:0] line_addr_t;

    // memory transaction tag, zero means no tag
    typedef logic [3:0] mem_tag_t;
    typedef logic [2:0] lq_idx_t;

    typedef enum logic [1:0] {
        mem_none,
        mem_load,
        mem_store
    } mem_command_e;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_e;

    typedef enum logic {
        kind_load,
        kind_store
    } req_kind_e;

    typedef enum logic [1:0] {
        mshr_invalid,
        mshr_pending,
        mshr_wait_data
    } mshr_state_e;

    typedef struct packed {
        logic    valid;
        addr_t   addr;
        lq_idx_t lq_idx;
    } load_req_t;

    typedef struct packed {
        logic      valid;
        addr_t     addr;
        mem_size_e size;
        data_t     data;
    } store_req_t;

    // one waiting access in a miss queue
    typedef struct packed {
        req_kind_e kind;
        mem_size_e size;
        data_t     data;
        offset_t   offset;
        lq_idx_t   lq_idx;
    } queue_pkt_t;

    typedef struct packed {
        mem_command_e command;
        addr_t        addr;
        block_t       data;
    } mem_req_t;

    typedef struct packed {
        logic    valid;
        lq_idx_t lq_idx;
        data_t   data;
    } load_done_t;

endpackage

//--- miss_queue.sv
`timescale 1ns/1ps

module miss_queue import dcache_pkg::*; #(
    parameter int queue_depth = 4
) (
    input  logic                         clock,
    input  logic                         reset,
    input  queue_pkt_t [1:0]             push_pkts,
    input  logic [1:0]                   push_valid,
    input  logic                         drain,
    output logic [1:0]                   push_accept,
    output queue_pkt_t [queue_depth-1:0] drain_pkts,
    output logic [queue_depth-1:0]       drain_valid
);

    localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
    localparam int cnt_w = $clog2(queue_depth + 1);

    queue_pkt_t [queue_depth-1:0] slots, next_slots;
    logic [ptr_w-1:0]             head, next_head;
    logic [ptr_w-1:0]             tail, next_tail;
    logic [cnt_w-1:0]             count, next_count;

    function automatic logic [ptr_w-1:0] wrap_inc(input logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(queue_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    always_comb begin
        logic [ptr_w-1:0] rd_ptr;

        next_slots  = slots;
        next_head   = head;
        next_tail   = tail;
        next_count  = count;
        push_accept = '0;

        // oldest packet first
        rd_ptr = head;
        for (int i = 0; i < queue_depth; i++) begin
            drain_pkts[i]  = slots[rd_ptr];
            drain_valid[i] = drain && (i < int'(count));
            rd_ptr         = wrap_inc(rd_ptr);
        end

        if (drain) begin
            // everything leaves at once, pushes dropped
            next_head  = tail;
            next_count = '0;
        end else begin
            // load slot goes in ahead of the store slot
            for (int s = 0; s < 2; s++) begin
                if (push_valid[s] && next_count < cnt_w'(queue_depth)) begin
                    next_slots[next_tail] = push_pkts[s];
                    next_tail             = wrap_inc(next_tail);
                    next_count            = next_count + 1'b1;
                    push_accept[s]        = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= next_head;
            tail  <= next_tail;
            count <= next_count;
        end
    end

    always_ff @(posedge clock) begin
        slots <= next_slots;
    end

endmodule

//--- mshr_file.sv
`timescale 1ns/1ps

module mshr_file import dcache_pkg::*; #(
    parameter int mshr_entries = 4,
    parameter int queue_depth  = 4
) (
    input  logic                         clock,
    input  logic                         reset,
    input  load_req_t                    load_req,
    input  logic                         load_miss,
    input  store_req_t                   store_req,
    input  logic                         store_miss,
    input  logic                         evict,
    input  mem_tag_t                     mem_grant_tag,
    input  mem_tag_t                     mem_data_tag,
    output logic                         load_miss_accept,
    output logic                         store_miss_accept,
    output mem_req_t                     fetch,
    output logic                         fill_valid,
    output line_addr_t                   fill_line,
    output queue_pkt_t [queue_depth-1:0] drain_pkts,
    output logic [queue_depth-1:0]       drain_valid
);

    typedef struct packed {
        mshr_state_e state;
        line_addr_t  line;
        mem_tag_t    tag;
    } mshr_entry_t;

    mshr_entry_t [mshr_entries-1:0] entries, next_entries;

    queue_pkt_t [mshr_entries-1:0][1:0]             push_pkts;
    logic [mshr_entries-1:0][1:0]                   push_valid;
    logic [mshr_entries-1:0][1:0]                   push_accept;
    logic [mshr_entries-1:0]                        drain;
    queue_pkt_t [mshr_entries-1:0][queue_depth-1:0] queue_pkts;
    logic [mshr_entries-1:0][queue_depth-1:0]       queue_valid;

    // port 0 is the load port, port 1 the store port
    logic [1:0]       miss;
    line_addr_t [1:0] req_line;
    queue_pkt_t [1:0] req_pkt;
    logic [1:0]       miss_accept;

    assign miss        = {store_miss, load_miss};
    assign req_line[0] = load_req.addr[31:3];
    assign req_line[1] = store_req.addr[31:3];
    assign req_pkt[0]  = '{kind: kind_load, size: size_word, data: '0,
                           offset: load_req.addr[2:0], lq_idx: load_req.lq_idx};
    assign req_pkt[1]  = '{kind: kind_store, size: store_req.size, data: store_req.data,
                           offset: store_req.addr[2:0], lq_idx: '0};

    assign load_miss_accept  = miss_accept[0];
    assign store_miss_accept = miss_accept[1];

    for (genvar j = 0; j < mshr_entries; j++) begin : g_queue
        miss_queue #(
            .queue_depth(queue_depth)
        ) u_queue (
            .clock      (clock),
            .reset      (reset),
            .push_pkts  (push_pkts[j]),
            .push_valid (push_valid[j]),
            .drain      (drain[j]),
            .push_accept(push_accept[j]),
            .drain_pkts (queue_pkts[j]),
            .drain_valid(queue_valid[j])
        );
    end

    // data return for an entry waiting on this tag
    always_comb begin
        drain       = '0;
        fill_valid  = 1'b0;
        fill_line   = '0;
        drain_pkts  = '0;
        drain_valid = '0;
        for (int j = 0; j < mshr_entries; j++) begin
            if (entries[j].state == mshr_wait_data && entries[j].tag == mem_data_tag) begin
                drain[j]    = 1'b1;
                fill_valid  = 1'b1;
                fill_line   = entries[j].line;
                drain_pkts  = queue_pkts[j];
                drain_valid = queue_valid[j];
            end
        end
    end

    always_comb begin
        logic matched;
        logic found;

        next_entries = entries;
        push_pkts    = '0;
        push_valid   = '0;
        miss_accept  = '0;
        fetch        = '{command: mem_none, addr: '0, data: '0};

        // join the entry for the line, else take the lowest free one
        for (int p = 0; p < 2; p++) begin
            matched = 1'b0;
            for (int j = 0; j < mshr_entries; j++) begin
                if (miss[p] && next_entries[j].state != mshr_invalid
                        && next_entries[j].line == req_line[p]) begin
                    matched          = 1'b1;
                    push_pkts[j][p]  = req_pkt[p];
                    push_valid[j][p] = 1'b1;
                    miss_accept[p]   = push_accept[j][p];
                end
            end
            for (int j = 0; j < mshr_entries; j++) begin
                if (miss[p] && !matched && next_entries[j].state == mshr_invalid) begin
                    matched               = 1'b1;
                    next_entries[j].state = mshr_pending;
                    next_entries[j].line  = req_line[p];
                    push_pkts[j][p]       = req_pkt[p];
                    push_valid[j][p]      = 1'b1;
                    miss_accept[p]        = push_accept[j][p];
                end
            end
        end

        // lowest pending entry asks for its line, held off by a write-back
        found = 1'b0;
        for (int j = 0; j < mshr_entries; j++) begin
            if (!evict && !found && entries[j].state == mshr_pending) begin
                found = 1'b1;
                fetch = '{command: mem_load, addr: {entries[j].line, 3'b000}, data: '0};
                if (mem_grant_tag != '0) begin
                    next_entries[j].state = mshr_wait_data;
                    next_entries[j].tag   = mem_grant_tag;
                end
            end
        end

        for (int j = 0; j < mshr_entries; j++) begin
            if (drain[j]) begin
                next_entries[j].state = mshr_invalid;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            entries <= '0;
        end else begin
            entries <= next_entries;
        end
    end

endmodule

//--- cache_array.sv
`timescale 1ns/1ps

module cache_array import dcache_pkg::*; #(
    parameter int num_lines   = 16,
    parameter int queue_depth = 4
) (
    input  logic                         clock,
    input  logic                         reset,
    input  load_req_t                    load_req,
    input  store_req_t                   store_req,
    input  logic                         load_miss_accept,
    input  logic                         store_miss_accept,
    input  logic                         fill_valid,
    input  line_addr_t                   fill_line,
    input  queue_pkt_t [queue_depth-1:0] drain_pkts,
    input  logic [queue_depth-1:0]       drain_valid,
    input  mem_req_t                     fetch,
    input  block_t                       mem_data,
    output logic                         load_miss,
    output logic                         store_miss,
    output logic                         evict,
    output logic                         load_accept,
    output data_t                        load_hit_data,
    output logic                         load_hit_valid,
    output logic                         store_accept,
    output load_done_t                   load_done,
    output mem_req_t                     mem_req
);

    localparam int index_w = $clog2(num_lines);
    localparam int tag_w   = $bits(line_addr_t) - index_w;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [tag_w-1:0] tag;
        block_t           block;
    } line_t;

    line_t [num_lines-1:0] lines, next_lines;

    logic [index_w-1:0] fill_idx, load_idx, store_idx;
    logic [tag_w-1:0]   fill_tag, load_tag, store_tag;

    assign fill_idx  = fill_line[index_w-1:0];
    assign fill_tag  = fill_line[$bits(line_addr_t)-1:index_w];
    assign load_idx  = load_req.addr[3 +: index_w];
    assign load_tag  = load_req.addr[31 -: tag_w];
    assign store_idx = store_req.addr[3 +: index_w];
    assign store_tag = store_req.addr[31 -: tag_w];

    function automatic block_t merge_store(input block_t blk, input offset_t off,
                                           input mem_size_e size, input data_t data);
        block_t merged;

        merged = blk;
        case (size)
            size_byte: merged[{off, 3'b000} +: 8]       = data[7:0];
            size_half: merged[{off[2:1], 4'b0000} +: 16] = data[15:0];
            default:   merged[{off[2], 5'b00000} +: 32]  = data;
        endcase
        return merged;
    endfunction

    // aligned word holding the byte
    function automatic data_t word_at(input block_t blk, input offset_t off);
        return blk[{off[2], 5'b00000} +: 32];
    endfunction

    always_comb begin
        next_lines     = lines;
        mem_req        = fetch;
        evict          = 1'b0;
        load_done      = '0;
        load_accept    = 1'b0;
        load_hit_data  = '0;
        load_hit_valid = 1'b0;
        load_miss      = 1'b0;
        store_accept   = 1'b0;
        store_miss     = 1'b0;

        if (fill_valid) begin
            // dirty victim goes out in place of the fetch
            if (lines[fill_idx].valid && lines[fill_idx].dirty) begin
                evict   = 1'b1;
                mem_req = '{command: mem_store,
                            addr: {lines[fill_idx].tag, fill_idx, 3'b000},
                            data: lines[fill_idx].block};
            end
            next_lines[fill_idx] = '{valid: 1'b1, dirty: 1'b0, tag: fill_tag, block: mem_data};
            // replay the queue in age order
            for (int i = 0; i < queue_depth; i++) begin
                if (drain_valid[i]) begin
                    if (drain_pkts[i].kind == kind_store) begin
                        next_lines[fill_idx].block = merge_store(next_lines[fill_idx].block,
                            drain_pkts[i].offset, drain_pkts[i].size, drain_pkts[i].data);
                        next_lines[fill_idx].dirty = 1'b1;
                    end else begin
                        load_done = '{valid: 1'b1, lq_idx: drain_pkts[i].lq_idx,
                            data: word_at(next_lines[fill_idx].block, drain_pkts[i].offset)};
                    end
                end
            end
        end

        // lookups see the line as just filled, load ahead of store
        if (load_req.valid) begin
            if (next_lines[load_idx].valid && next_lines[load_idx].tag == load_tag) begin
                load_accept    = 1'b1;
                load_hit_valid = 1'b1;
                load_hit_data  = word_at(next_lines[load_idx].block, load_req.addr[2:0]);
            end else begin
                load_miss   = 1'b1;
                load_accept = load_miss_accept;
            end
        end

        if (store_req.valid) begin
            if (next_lines[store_idx].valid && next_lines[store_idx].tag == store_tag) begin
                store_accept                = 1'b1;
                next_lines[store_idx].block = merge_store(next_lines[store_idx].block,
                    store_req.addr[2:0], store_req.size, store_req.data);
                next_lines[store_idx].dirty = 1'b1;
            end else begin
                store_miss   = 1'b1;
                store_accept = store_miss_accept;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_lines; i++) begin
                lines[i].valid <= 1'b0;
                lines[i].dirty <= 1'b0;
            end
        end else begin
            lines <= next_lines;
        end
    end

endmodule

//--- dcache.sv
`timescale 1ns/1ps

module dcache import dcache_pkg::*; #(
    parameter int num_lines    = 16,
    parameter int mshr_entries = 4,
    parameter int queue_depth  = 4
) (
    input  logic       clock,
    input  logic       reset,
    input  load_req_t  load_req,
    input  store_req_t store_req,
    output logic       load_accept,
    output data_t      load_hit_data,
    output logic       load_hit_valid,
    output logic       store_accept,
    output load_done_t load_done,
    output mem_req_t   mem_req,
    input  mem_tag_t   mem_grant_tag,
    input  block_t     mem_data,
    input  mem_tag_t   mem_data_tag
);

    // array to miss file
    logic load_miss;
    logic store_miss;
    logic evict;

    // miss file to array
    logic                         load_miss_accept;
    logic                         store_miss_accept;
    mem_req_t                     fetch;
    logic                         fill_valid;
    line_addr_t                   fill_line;
    queue_pkt_t [queue_depth-1:0] drain_pkts;
    logic [queue_depth-1:0]       drain_valid;

    cache_array #(
        .num_lines  (num_lines),
        .queue_depth(queue_depth)
    ) u_array (
        .clock            (clock),
        .reset            (reset),
        .load_req         (load_req),
        .store_req        (store_req),
        .load_miss_accept (load_miss_accept),
        .store_miss_accept(store_miss_accept),
        .fill_valid       (fill_valid),
        .fill_line        (fill_line),
        .drain_pkts       (drain_pkts),
        .drain_valid      (drain_valid),
        .fetch            (fetch),
        .mem_data         (mem_data),
        .load_miss        (load_miss),
        .store_miss       (store_miss),
        .evict            (evict),
        .load_accept      (load_accept),
        .load_hit_data    (load_hit_data),
        .load_hit_valid   (load_hit_valid),
        .store_accept     (store_accept),
        .load_done        (load_done),
        .mem_req          (mem_req)
    );

    mshr_file #(
        .mshr_entries(mshr_entries),
        .queue_depth (queue_depth)
    ) u_mshr (
        .clock            (clock),
        .reset            (reset),
        .load_req         (load_req),
        .load_miss        (load_miss),
        .store_req        (store_req),
        .store_miss       (store_miss),
        .evict            (evict),
        .mem_grant_tag    (mem_grant_tag),
        .mem_data_tag     (mem_data_tag),
        .load_miss_accept (load_miss_accept),
        .store_miss_accept(store_miss_accept),
        .fetch            (fetch),
        .fill_valid       (fill_valid),
        .fill_line        (fill_line),
        .drain_pkts       (drain_pkts),
        .drain_valid      (drain_valid)
    );

endmodule

//--- tb_memory.sv
`timescale 1ns/1ps

module tb_memory import dcache_pkg::*; #(
    parameter addr_t base_addr    = 32'h0000_2000,
    parameter int    window_lines = 64
) (
    input  logic       clock,
    input  logic       reset,
    input  mem_req_t   mem_req,
    input  logic [3:0] return_delay,
    output mem_tag_t   mem_grant_tag,
    output block_t     mem_data,
    output mem_tag_t   mem_data_tag
);

    block_t     backing  [window_lines];
    logic       busy     [16];
    line_addr_t tag_line [16];
    int         due      [16];
    int         cycle;

    // starting contents, a function of the full word address
    function automatic data_t fill_word(input addr_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic int line_slot(input line_addr_t line);
        return int'(line - base_addr[31:3]);
    endfunction

    // lowest free tag, tag 0 is never handed out
    always_comb begin
        mem_grant_tag = '0;
        if (mem_req.command == mem_load) begin
            for (int t = 15; t >= 1; t--) begin
                if (!busy[t]) begin
                    mem_grant_tag = mem_tag_t'(t);
                end
            end
        end
    end

    always @(posedge clock) begin
        logic  returned;
        addr_t addr;

        if (reset) begin
            for (int i = 0; i < window_lines; i++) begin
                addr       = base_addr + addr_t'(i * 8);
                backing[i] <= {fill_word(addr + 32'd4), fill_word(addr)};
            end
            for (int t = 0; t < 16; t++) begin
                busy[t] <= 1'b0;
            end
            cycle        <= 0;
            mem_data     <= '0;
            mem_data_tag <= '0;
        end else begin
            cycle        <= cycle + 1;
            mem_data_tag <= '0;
            returned     = 1'b0;
            // one line back per cycle, lowest ready tag first
            for (int t = 1; t < 16; t++) begin
                if (!returned && busy[t] && due[t] <= cycle) begin
                    returned     = 1'b1;
                    busy[t]      <= 1'b0;
                    mem_data_tag <= mem_tag_t'(t);
                    mem_data     <= backing[line_slot(tag_line[t])];
                end
            end
            if (mem_req.command == mem_load && mem_grant_tag != '0) begin
                busy[mem_grant_tag]     <= 1'b1;
                tag_line[mem_grant_tag] <= mem_req.addr[31:3];
                due[mem_grant_tag]      <= cycle + int'(return_delay);
            end
            // write-back of a dirty victim
            if (mem_req.command == mem_store) begin
                backing[line_slot(mem_req.addr[31:3])] <= mem_req.data;
            end
        end
    end

endmodule

//--- tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache import dcache_pkg::*; ();

    localparam int    num_lines    = 16;
    localparam int    mshr_entries = 4;
    localparam int    queue_depth  = 4;
    localparam addr_t base_addr    = 32'h0000_2000;
    localparam int    window_lines = 64;
    localparam int    num_cycles   = 4000;
    localparam int    hold_limit   = 500;
    localparam int    run_limit    = 20000;

    logic       clock;
    logic       reset;
    load_req_t  load_req;
    store_req_t store_req;
    logic       load_accept;
    data_t      load_hit_data;
    logic       load_hit_valid;
    logic       store_accept;
    load_done_t load_done;
    mem_req_t   mem_req;
    mem_tag_t   mem_grant_tag;
    block_t     mem_data;
    mem_tag_t   mem_data_tag;
    logic [3:0] return_delay;

    // architectural memory, one byte per entry
    logic [7:0]  model [window_lines * 8];
    logic        pending [8];
    data_t       expected [8];
    line_addr_t  pending_line [8];
    line_addr_t  granted_line [16];
    logic [31:0] lfsr;
    logic [5:0]  last_line;
    logic        load_free;
    logic        store_free;
    int          load_hold;
    int          store_hold;
    int          rejects;
    int          sweep_addr;

    dcache #(
        .num_lines   (num_lines),
        .mshr_entries(mshr_entries),
        .queue_depth (queue_depth)
    ) DUT (
        .clock         (clock),
        .reset         (reset),
        .load_req      (load_req),
        .store_req     (store_req),
        .load_accept   (load_accept),
        .load_hit_data (load_hit_data),
        .load_hit_valid(load_hit_valid),
        .store_accept  (store_accept),
        .load_done     (load_done),
        .mem_req       (mem_req),
        .mem_grant_tag (mem_grant_tag),
        .mem_data      (mem_data),
        .mem_data_tag  (mem_data_tag)
    );

    tb_memory #(
        .base_addr   (base_addr),
        .window_lines(window_lines)
    ) u_memory (
        .clock        (clock),
        .reset        (reset),
        .mem_req      (mem_req),
        .return_delay (return_delay),
        .mem_grant_tag(mem_grant_tag),
        .mem_data     (mem_data),
        .mem_data_tag (mem_data_tag)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // galois form, taps 32 22 2 1
    function automatic logic lfsr_step();
        logic out_bit;
        out_bit = lfsr[0];
        lfsr    = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        return out_bit;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[30:0], lfsr_step()};
        end
        return bits;
    endfunction

    // same starting contents as the backing store
    function automatic data_t fill_word(input addr_t addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic data_t model_word(input addr_t addr);
        int s;
        s = int'(addr - base_addr) & ~3;
        return {model[s + 3], model[s + 2], model[s + 1], model[s]};
    endfunction

    function automatic block_t model_block(input addr_t addr);
        return {model_word(addr + 32'd4), model_word(addr)};
    endfunction

    function automatic void model_store(input store_req_t req);
        int s;
        int n;
        s = int'(req.addr - base_addr);
        n = (req.size == size_byte) ? 1 : (req.size == size_half) ? 2 : 4;
        for (int b = 0; b < n; b++) begin
            model[s + b] = req.data[8 * b +: 8];
        end
    endfunction

    function automatic int free_index();
        int idx;
        idx = -1;
        for (int i = 7; i >= 0; i--) begin
            if (!pending[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic int outstanding(input logic match_line, input line_addr_t line);
        int n;
        n = 0;
        for (int i = 0; i < 8; i++) begin
            if (pending[i] && (!match_line || pending_line[i] == line)) begin
                n++;
            end
        end
        return n;
    endfunction

    // half the time stay on the last line so queues fill up
    function automatic logic [5:0] pick_line();
        if (random_bits(1) != 0) begin
            last_line = 6'(random_bits(6));
        end
        return last_line;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Test FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input string name, input data_t want, input data_t got);
        if (got !== want) begin
            report_failure($sformatf("FAILED %s expected %h actual %h", name, want, got));
        end
    endtask

    task automatic check_block(input string name, input block_t want, input block_t got);
        if (got !== want) begin
            report_failure($sformatf("FAILED %s expected %h actual %h", name, want, got));
        end
    endtask

    task automatic check_idx(input string name, input lq_idx_t want, input lq_idx_t got);
        if (got !== want) begin
            report_failure($sformatf("FAILED %s expected %0d actual %0d", name, want, got));
        end
    endtask

    task automatic check_flag(input string name, input logic want, input logic got);
        if (got !== want) begin
            report_failure($sformatf("FAILED %s expected %b actual %b", name, want, got));
        end
    endtask

    task automatic check_command(input string name, input mem_command_e want,
                                 input mem_command_e got);
        if (got !== want) begin
            report_failure($sformatf("FAILED %s expected %0d actual %0d", name, want, got));
        end
    endtask

    task automatic drive_cycle(input logic sweeping);
        load_req_t  next_load;
        store_req_t next_store;
        addr_t      addr;
        int         idx;
        logic       want_load;
        logic [1:0] size_pick;
        logic [2:0] off;

        // a rejected request stays on the port unchanged
        if (load_free) begin
            next_load = '0;
            idx       = free_index();
            if (sweeping) begin
                addr      = base_addr + addr_t'(sweep_addr);
                want_load = sweep_addr < window_lines * 8;
            end else begin
                addr      = base_addr + addr_t'({pick_line(), 3'(random_bits(3))});
                want_load = random_bits(2) != 0;
            end
            // one outstanding load per line keeps load_done unambiguous
            if (want_load && idx >= 0 && outstanding(1'b1, addr[31:3]) == 0) begin
                next_load = '{valid: 1'b1, addr: addr, lq_idx: lq_idx_t'(idx)};
                if (sweeping) begin
                    sweep_addr += 4;
                end
            end
            load_req <= next_load;
        end
        if (store_free) begin
            next_store = '0;
            if (!sweeping && random_bits(1) != 0) begin
                size_pick = 2'(random_bits(2));
                off       = 3'(random_bits(3));
                case (size_pick)
                    2'd0: next_store.size = size_byte;
                    2'd1: begin
                        next_store.size = size_half;
                        off[0]          = 1'b0;
                    end
                    default: begin
                        next_store.size = size_word;
                        off[1:0]        = 2'b00;
                    end
                endcase
                next_store.valid = 1'b1;
                next_store.addr  = base_addr + addr_t'({pick_line(), off});
                next_store.data  = random_bits(32);
            end
            store_req <= next_store;
        end
        return_delay <= 4'(2 + random_bits(4) % 11);
    endtask

    task automatic observe_cycle();
        int found;

        // a returning line answers the load waiting on it
        found = -1;
        if (mem_data_tag != '0) begin
            for (int i = 0; i < 8; i++) begin
                if (pending[i] && pending_line[i] == granted_line[mem_data_tag]) begin
                    found = i;
                end
            end
        end
        check_flag("load_done valid", found >= 0, load_done.valid);
        if (found >= 0) begin
            check_idx("load_done index", lq_idx_t'(found), load_done.lq_idx);
            check_data("load miss data", expected[found], load_done.data);
            pending[found] = 1'b0;
        end

        // victim must match the model before this cycle's stores
        if (mem_req.command == mem_store) begin
            check_block("write-back block", model_block(mem_req.addr), mem_req.data);
        end
        if (mem_req.command == mem_load && mem_grant_tag != '0) begin
            granted_line[mem_grant_tag] = mem_req.addr[31:3];
        end

        // load before store within the cycle
        if (load_hit_valid) begin
            check_flag("load hit accept", 1'b1, load_accept && load_req.valid);
            check_data("load hit data", model_word(load_req.addr), load_hit_data);
        end else if (load_req.valid && load_accept) begin
            pending[load_req.lq_idx]      = 1'b1;
            expected[load_req.lq_idx]     = model_word(load_req.addr);
            pending_line[load_req.lq_idx] = load_req.addr[31:3];
        end
        if (store_req.valid && store_accept) begin
            model_store(store_req);
        end

        load_free  = !load_req.valid || load_accept;
        store_free = !store_req.valid || store_accept;
        rejects    += int'(!load_free) + int'(!store_free);
        load_hold  = load_free ? 0 : load_hold + 1;
        store_hold = store_free ? 0 : store_hold + 1;
        if (load_hold > hold_limit || store_hold > hold_limit) begin
            report_failure("a rejected request was never accepted");
        end
    endtask

    initial begin
        int    cycle;
        data_t word;

        lfsr         = 32'h6834;
        reset        = 1'b1;
        load_req     = '0;
        store_req    = '0;
        return_delay = 4'd2;
        last_line    = '0;
        load_free    = 1'b1;
        store_free   = 1'b1;
        load_hold    = 0;
        store_hold   = 0;
        rejects      = 0;
        sweep_addr   = 0;
        for (int i = 0; i < 8; i++) begin
            pending[i] = 1'b0;
        end
        for (int a = 0; a < window_lines * 8; a += 4) begin
            word = fill_word(base_addr + addr_t'(a));
            for (int b = 0; b < 4; b++) begin
                model[a + b] = word[8 * b +: 8];
            end
        end

        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_command("idle mem_req", mem_none, mem_req.command);
        check_flag("idle load_done", 1'b0, load_done.valid);
        check_flag("idle load_hit_valid", 1'b0, load_hit_valid);
        check_flag("idle load_accept", 1'b0, load_accept);
        check_flag("idle store_accept", 1'b0, store_accept);

        // random traffic, then a sweep of loads over the window
        cycle = 0;
        while (!(cycle >= num_cycles && sweep_addr >= window_lines * 8 && load_free
                 && store_free && outstanding(1'b0, '0) == 0)) begin
            if (cycle == run_limit) begin
                report_failure("traffic did not drain before the run limit");
            end else begin
                @(posedge clock);
                drive_cycle(cycle >= num_cycles);
                @(negedge clock);
                observe_cycle();
                cycle++;
            end
        end

        if (rejects == 0) begin
            report_failure("no miss was ever rejected, back-pressure not exercised");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

//--- tb.f
dcache_pkg.sv
miss_queue.sv
mshr_file.sv
cache_array.sv
dcache.sv
tb_memory.sv
tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - dcache_pkg.sv
  - miss_queue.sv
  - mshr_file.sv
  - cache_array.sv
  - dcache.sv
  - target: test
    files:
      - tb_memory.sv
      - tb_dcache.sv
